/* include/fm_defines.svh */
`ifndef FM_DEFINES_SVH
`define FM_DEFINES_SVH

// operator slots in one full sequence
`define FM_SLOTS 24

// channels, also the depth of the channel memories
`define FM_CHANNELS 6

// channel code jumped over after code 2
// codes 3 and 7 name no channel
`define FM_CH_SKIP 3'd3

// last channel code before the operator advances
`define FM_CH_LAST 3'd6

`endif

/* logic/fm_pkg.sv */
`default_nettype none

package fm_pkg;

	// one operator slot, channel code in the low bits
	typedef struct packed {
		logic [1:0] op;
		logic [2:0] ch;
	} slot_t;

	typedef enum logic [3:0] {
		REG_DT_MUL,
		REG_TL,
		REG_KS_AR,
		REG_AM_D1R,
		REG_D2R,
		REG_D1L_RR,
		REG_SSG,
		REG_FB_ALG,
		REG_FNUM_LO,
		REG_BLOCK_FNHI,
		REG_PAN_PMS,
		REG_KEYON
	} reg_kind_t;

	// host write, only slot.ch counts for channel kinds
	typedef struct packed {
		reg_kind_t  kind;
		slot_t      slot;
		logic [7:0] data;
	} reg_write_t;

	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic       amen;
		logic [4:0] d1r;
		logic [4:0] d2r;
		logic [3:0] d1l;
		logic [3:0] rr;
		logic       ssg_en;
		logic [2:0] ssg_eg;
	} op_regs_t;

	// fnum and block only change on the fnum low byte write
	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  latch_block;
		logic [2:0]  latch_fnhi;
		logic [2:0]  fb;
		logic [2:0]  alg;
		logic [1:0]  ams;
		logic [2:0]  pms;
	} ch_regs_t;

	typedef struct packed {
		logic [1:0] rl;
	} ch_pan_t;

	typedef struct packed {
		slot_t    slot;
		logic     zero;
		op_regs_t op;
		ch_regs_t ch;
		ch_pan_t  pan;
		logic     keyon;
	} slot_out_t;

endpackage

`default_nettype wire

/* logic/fm_shreg.sv */
`default_nettype none

// rotating memory, each entry comes back after STAGES cycles
module fm_shreg import fm_pkg::*; #(
	parameter type T = slot_t,
	parameter int STAGES = 2,
	parameter T RSTVAL = T'(0)
) (
	input  logic clk,
	input  logic rst,
	input  T     din,
	output T     dout
);

	T stage [STAGES];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < STAGES; i++) begin
				stage[i] <= RSTVAL;
			end
		end else begin
			stage[0] <= din;
			for (int i = 1; i < STAGES; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	// oldest entry
	assign dout = stage[STAGES-1];

endmodule

`default_nettype wire

/* logic/fm_slot_counter.sv */
`default_nettype none

`include "fm_defines.svh"

module fm_slot_counter import fm_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	output slot_t slot,
	output logic  zero
);

	slot_t nxt;

	// channel codes run 0,1,2,4,5,6 then the operator steps
	always_comb begin
		nxt = slot;
		if (slot.ch == `FM_CH_LAST) begin
			nxt.op = slot.op + 2'd1;
			nxt.ch = 3'd0;
		end else if (slot.ch + 3'd1 == `FM_CH_SKIP) begin
			nxt.ch = slot.ch + 3'd2;
		end else begin
			nxt.ch = slot.ch + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
		end else begin
			slot <= nxt;
		end
	end

	// start of the 24 slot sequence
	assign zero = (slot == '0);

endmodule

`default_nettype wire

/* logic/fm_write_port.sv */
`default_nettype none

`include "fm_defines.svh"

module fm_write_port import fm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_valid,
	output logic       wr_ready,
	input  reg_write_t wr,
	input  slot_t      cur_slot,
	output logic       apply,
	output reg_write_t cmd
);

	logic       busy;
	reg_write_t held;
	logic [2:0] tgt_ch;
	logic       tgt_bad;
	logic       accept;
	logic       slot_hit;

	// key-on carries its channel in the data byte
	assign tgt_ch = (wr.kind == REG_KEYON) ? wr.data[2:0] : wr.slot.ch;
	assign tgt_bad = (tgt_ch == `FM_CH_SKIP) || (tgt_ch == `FM_CH_SKIP + 3'd4);

	assign wr_ready = !busy;
	assign accept = wr_valid && wr_ready;

	// when the held write may land
	always_comb begin
		case (held.kind)
			REG_FB_ALG, REG_FNUM_LO, REG_BLOCK_FNHI, REG_PAN_PMS: begin
				slot_hit = (held.slot.ch == cur_slot.ch);
			end
			REG_KEYON: begin
				slot_hit = 1'b1;
			end
			default: begin
				slot_hit = (held.slot == cur_slot);
			end
		endcase
	end

	assign apply = busy && slot_hit;
	assign cmd = held;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else if (apply) begin
			busy <= 1'b0;
		end else if (accept && !tgt_bad) begin
			busy <= 1'b1;
		end
	end

	// writes to unused channel codes are dropped here
	always_ff @(posedge clk) begin
		if (accept && !tgt_bad) begin
			held <= wr;
		end
	end

endmodule

`default_nettype wire

/* logic/fm_keyon.sv */
`default_nettype none

`include "fm_defines.svh"

module fm_keyon import fm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       apply,
	input  reg_write_t cmd,
	input  slot_t      cur_slot,
	output logic       keyon
);

	logic [3:0] pend_mask;
	logic [2:0] pend_ch;
	logic       kon_cur;
	logic       kon_nxt;

	// last key-on request, replayed on every pass of its channel
	always_ff @(posedge clk) begin
		if (rst) begin
			pend_mask <= 4'd0;
			pend_ch <= 3'd0;
		end else if (apply && cmd.kind == REG_KEYON) begin
			pend_mask <= cmd.data[7:4];
			pend_ch <= cmd.data[2:0];
		end
	end

	// one mask bit per operator of the channel
	assign kon_nxt = (cur_slot.ch == pend_ch) ? pend_mask[cur_slot.op] : kon_cur;

	fm_shreg #(
		.T(logic),
		.STAGES(`FM_SLOTS),
		.RSTVAL(1'b0)
	) u_kon_mem (
		.clk  (clk),
		.rst  (rst),
		.din  (kon_nxt),
		.dout (kon_cur)
	);

	assign keyon = kon_cur;

endmodule

`default_nettype wire

/* logic/fm_reg.sv */
`default_nettype none

`include "fm_defines.svh"

module fm_reg import fm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       apply,
	input  reg_write_t cmd,
	output slot_t      cur_slot,
	output slot_out_t  slot_out
);

	logic       zero;
	logic [7:0] d;
	logic       keyon;
	op_regs_t   op_cur;
	op_regs_t   op_nxt;
	ch_regs_t   ch_cur;
	ch_regs_t   ch_nxt;
	ch_pan_t    pan_cur;
	ch_pan_t    pan_nxt;

	assign d = cmd.data;

	fm_slot_counter u_cnt (
		.clk  (clk),
		.rst  (rst),
		.slot (cur_slot),
		.zero (zero)
	);

	// operator fields, replaced group by group
	always_comb begin
		op_nxt = op_cur;
		if (apply) begin
			case (cmd.kind)
				REG_DT_MUL: begin
					op_nxt.dt1 = d[6:4];
					op_nxt.mul = d[3:0];
				end
				REG_TL: op_nxt.tl = d[6:0];
				REG_KS_AR: begin
					op_nxt.ks = d[7:6];
					op_nxt.ar = d[4:0];
				end
				REG_AM_D1R: begin
					op_nxt.amen = d[7];
					op_nxt.d1r = d[4:0];
				end
				REG_D2R: op_nxt.d2r = d[4:0];
				REG_D1L_RR: begin
					op_nxt.d1l = d[7:4];
					op_nxt.rr = d[3:0];
				end
				REG_SSG: begin
					op_nxt.ssg_en = d[3];
					op_nxt.ssg_eg = d[2:0];
				end
				default: ;
			endcase
		end
	end

	// channel fields, block and fnum go through the latch
	always_comb begin
		ch_nxt = ch_cur;
		pan_nxt = pan_cur;
		if (apply) begin
			case (cmd.kind)
				REG_BLOCK_FNHI: begin
					ch_nxt.latch_block = d[5:3];
					ch_nxt.latch_fnhi = d[2:0];
				end
				REG_FNUM_LO: begin
					ch_nxt.block = ch_cur.latch_block;
					ch_nxt.fnum = {ch_cur.latch_fnhi, d};
				end
				REG_FB_ALG: begin
					ch_nxt.fb = d[5:3];
					ch_nxt.alg = d[2:0];
				end
				REG_PAN_PMS: begin
					pan_nxt.rl = d[7:6];
					ch_nxt.ams = d[5:4];
					ch_nxt.pms = d[2:0];
				end
				default: ;
			endcase
		end
	end

	fm_shreg #(
		.T(op_regs_t),
		.STAGES(`FM_SLOTS),
		.RSTVAL('0)
	) u_op_mem (
		.clk  (clk),
		.rst  (rst),
		.din  (op_nxt),
		.dout (op_cur)
	);

	fm_shreg #(
		.T(ch_regs_t),
		.STAGES(`FM_CHANNELS),
		.RSTVAL('0)
	) u_ch_mem (
		.clk  (clk),
		.rst  (rst),
		.din  (ch_nxt),
		.dout (ch_cur)
	);

	// both outputs on out of reset
	fm_shreg #(
		.T(ch_pan_t),
		.STAGES(`FM_CHANNELS),
		.RSTVAL(ch_pan_t'(2'b11))
	) u_pan_mem (
		.clk  (clk),
		.rst  (rst),
		.din  (pan_nxt),
		.dout (pan_cur)
	);

	fm_keyon u_kon (
		.clk      (clk),
		.rst      (rst),
		.apply    (apply),
		.cmd      (cmd),
		.cur_slot (cur_slot),
		.keyon    (keyon)
	);

	always_comb begin
		slot_out.slot = cur_slot;
		slot_out.zero = zero;
		slot_out.op = op_cur;
		slot_out.ch = ch_cur;
		slot_out.pan = pan_cur;
		slot_out.keyon = keyon;
	end

endmodule

`default_nettype wire

/* logic/fm_reg_top.sv */
`default_nettype none

module fm_reg_top import fm_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_valid,
	output logic       wr_ready,
	input  reg_write_t wr,
	output slot_out_t  slot_out
);

	logic       apply;
	reg_write_t cmd;
	slot_t      cur_slot;

	// host side, holds one write until its slot comes around
	fm_write_port u_wport (
		.clk      (clk),
		.rst      (rst),
		.wr_valid (wr_valid),
		.wr_ready (wr_ready),
		.wr       (wr),
		.cur_slot (cur_slot),
		.apply    (apply),
		.cmd      (cmd)
	);

	fm_reg u_reg (
		.clk      (clk),
		.rst      (rst),
		.apply    (apply),
		.cmd      (cmd),
		.cur_slot (cur_slot),
		.slot_out (slot_out)
	);

endmodule

`default_nettype wire

/* sim/fm_reg_asserts.sv */
`default_nettype none

module fm_reg_asserts import fm_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       wr_valid,
	input logic       busy,
	input logic       apply,
	input reg_write_t cmd
);

	timeunit 1ns;
	timeprecision 100ps;

	// a held write lands once and frees the port
	apply_one_cycle: assert property (@(posedge clk) disable iff (rst) apply |=> !apply)
		else $error("apply stayed high for more than one cycle");

	// an idle port with no request has nothing to land next cycle
	apply_only_busy: assert property (@(posedge clk) disable iff (rst)
		!busy && !wr_valid |=> !apply)
		else $error("apply raised while no write was held");

	// held command must not change until it lands
	cmd_stable: assert property (@(posedge clk) disable iff (rst)
		busy && $past(busy) |-> $stable(cmd))
		else $error("held command changed while busy");

endmodule

bind fm_write_port fm_reg_asserts u_asserts (
	.clk      (clk),
	.rst      (rst),
	.wr_valid (wr_valid),
	.busy     (busy),
	.apply    (apply),
	.cmd      (cmd)
);

`default_nettype wire

/* sim/fm_reg_tb.sv */
`default_nettype none

`include "fm_defines.svh"

module fm_reg_tb import fm_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// cycles of quiet host port before every slot shows its final state
	localparam int SETTLE = 26;
	// 6 tests of up to 25 writes, 26 cycles each
	localparam int MAX_CYCLES = 6 * 25 * 26 + 100;

	logic       clk;
	logic       rst;
	logic       wr_valid;
	logic       wr_ready;
	reg_write_t wr;
	slot_out_t  slot_out;

	// reference model
	op_regs_t   op_model [`FM_SLOTS];
	ch_regs_t   ch_model [`FM_CHANNELS];
	ch_pan_t    pan_model [`FM_CHANNELS];
	logic [3:0] kon_model [`FM_CHANNELS];

	logic [31:0] rng;
	int          errors;
	int          checks;
	int          tests;
	int          cycles;
	int          quiet;
	int          exp_idx;
	int          mon_pos;
	slot_t       mon_slot;

	fm_reg_top DUT (
		.clk      (clk),
		.rst      (rst),
		.wr_valid (wr_valid),
		.wr_ready (wr_ready),
		.wr       (wr),
		.slot_out (slot_out)
	);

	always #5 clk = !clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// position 0..5 to channel code, code 3 never used
	function automatic logic [2:0] code_of(input int pos);
		return (3'(pos) < `FM_CH_SKIP) ? 3'(pos) : 3'(pos + 1);
	endfunction

	function automatic int pos_of(input logic [2:0] code);
		return (code > `FM_CH_SKIP) ? int'(code) - 1 : int'(code);
	endfunction

	function automatic reg_write_t make_write(input reg_kind_t kind, input logic [1:0] op,
			input logic [2:0] ch, input logic [7:0] data);
		reg_write_t w;
		w.kind = kind;
		w.slot.op = op;
		w.slot.ch = ch;
		w.data = data;
		return w;
	endfunction

	task automatic init_model();
		for (int i = 0; i < `FM_SLOTS; i++) begin
			op_model[i] = '0;
		end
		for (int i = 0; i < `FM_CHANNELS; i++) begin
			ch_model[i] = '0;
			pan_model[i].rl = 2'b11;
			kon_model[i] = 4'd0;
		end
	endtask

	// field map of one host write
	task automatic model_write(input reg_write_t w);
		logic [2:0] c;
		logic [7:0] d;
		int         p;
		int         s;
		d = w.data;
		c = (w.kind == REG_KEYON) ? d[2:0] : w.slot.ch;
		if (c == 3'd3 || c == 3'd7) begin
			return;
		end
		p = pos_of(c);
		s = int'(w.slot.op) * 6 + p;
		case (w.kind)
			REG_DT_MUL: {op_model[s].dt1, op_model[s].mul} = d[6:0];
			REG_TL: op_model[s].tl = d[6:0];
			REG_KS_AR: {op_model[s].ks, op_model[s].ar} = {d[7:6], d[4:0]};
			REG_AM_D1R: {op_model[s].amen, op_model[s].d1r} = {d[7], d[4:0]};
			REG_D2R: op_model[s].d2r = d[4:0];
			REG_D1L_RR: {op_model[s].d1l, op_model[s].rr} = d;
			REG_SSG: {op_model[s].ssg_en, op_model[s].ssg_eg} = d[3:0];
			REG_FB_ALG: {ch_model[p].fb, ch_model[p].alg} = d[5:0];
			REG_BLOCK_FNHI: {ch_model[p].latch_block, ch_model[p].latch_fnhi} = d[5:0];
			REG_FNUM_LO: begin
				ch_model[p].block = ch_model[p].latch_block;
				ch_model[p].fnum = {ch_model[p].latch_fnhi, d};
			end
			REG_PAN_PMS: begin
				pan_model[p].rl = d[7:6];
				ch_model[p].ams = d[5:4];
				ch_model[p].pms = d[2:0];
			end
			REG_KEYON: kon_model[p] = d[7:4];
			default: ;
		endcase
	endtask

	task automatic compare_slot(input slot_t got, input logic got_zero, input slot_t exp,
			input logic exp_zero);
		checks++;
		if (got !== exp || got_zero !== exp_zero) begin
			errors++;
			$display("Fail at %0t: slot op %0d ch %0d zero %b, expected op %0d ch %0d zero %b",
				$time, got.op, got.ch, got_zero, exp.op, exp.ch, exp_zero);
		end
	endtask

	task automatic compare_op(input op_regs_t got, input op_regs_t exp, input int idx);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: operator fields at slot %0d read %h, expected %h",
				$time, idx, got, exp);
		end
	endtask

	task automatic compare_ch(input ch_regs_t got, input ch_pan_t got_pan, input ch_regs_t exp,
			input ch_pan_t exp_pan, input int idx);
		checks++;
		if (got !== exp || got_pan !== exp_pan) begin
			errors++;
			$display("Fail at %0t: channel fields at slot %0d read %h pan %b, expected %h pan %b",
				$time, idx, got, got_pan.rl, exp, exp_pan.rl);
		end
	endtask

	task automatic compare_keyon(input logic got, input logic exp, input int idx);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: key-on at slot %0d read %b, expected %b", $time, idx, got, exp);
		end
	endtask

	// slot sequence every cycle, stored state once the host port has been quiet
	always @(negedge clk) begin
		if (rst) begin
			exp_idx = 0;
			quiet = SETTLE;
		end else begin
			mon_pos = exp_idx % 6;
			mon_slot.op = 2'(exp_idx / 6);
			mon_slot.ch = code_of(mon_pos);
			compare_slot(slot_out.slot, slot_out.zero, mon_slot, exp_idx == 0);
			if (!wr_ready || wr_valid) begin
				quiet = 0;
			end else if (quiet < SETTLE) begin
				quiet++;
			end
			if (quiet >= SETTLE) begin
				compare_op(slot_out.op, op_model[exp_idx], exp_idx);
				compare_ch(slot_out.ch, slot_out.pan, ch_model[mon_pos], pan_model[mon_pos],
					exp_idx);
				compare_keyon(slot_out.keyon, kon_model[mon_pos][mon_slot.op], exp_idx);
			end
			exp_idx = (exp_idx + 1) % `FM_SLOTS;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run went past %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	// called and returns 1 ns after a rising edge
	task automatic send(input reg_write_t w, output int waited);
		wr = w;
		wr_valid = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!wr_ready) begin
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		wr_valid = 1'b0;
		model_write(w);
	endtask

	task automatic wait_settled();
		while (quiet < SETTLE) begin
			@(posedge clk);
		end
		repeat (`FM_SLOTS) @(posedge clk);
		#1;
	endtask

	task automatic check_ready_kept();
		@(negedge clk);
		if (wr_ready !== 1'b1) begin
			errors++;
			$display("wr_ready dropped after a write to an unused channel code");
		end
		@(posedge clk);
		#1;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s done, %0d errors so far", tests, name, errors);
	endtask

	task automatic test_reset();
		if (wr_ready !== 1'b1) begin
			errors++;
			$display("wr_ready was not high after reset");
		end
		repeat (2 * `FM_SLOTS) @(posedge clk);
		#1;
		end_test("reset state");
	endtask

	task automatic test_op_fields();
		int         waited;
		reg_write_t w;
		for (int k = 0; k <= int'(REG_SSG); k++) begin
			repeat (3) begin
				w = make_write(reg_kind_t'(k), 2'(next_rand()), code_of(int'(next_rand() % 6)),
					8'(next_rand()));
				send(w, waited);
			end
		end
		wait_settled();
		end_test("operator fields");
	endtask

	task automatic test_block_latch();
		int         waited;
		logic [2:0] c;
		for (int i = 0; i < 2; i++) begin
			c = code_of(int'(next_rand() % 6));
			send(make_write(REG_BLOCK_FNHI, 2'd0, c, 8'(next_rand())), waited);
			wait_settled();
			send(make_write(REG_FNUM_LO, 2'd0, c, 8'(next_rand())), waited);
			wait_settled();
		end
		end_test("block latch");
	endtask

	task automatic test_channel_fields();
		int waited;
		for (int p = 0; p < `FM_CHANNELS; p++) begin
			send(make_write(REG_FB_ALG, 2'(next_rand()), code_of(p), 8'(next_rand())), waited);
			send(make_write(REG_PAN_PMS, 2'(next_rand()), code_of(p), 8'(next_rand())), waited);
		end
		wait_settled();
		end_test("channel fields");
	endtask

	task automatic test_keyon();
		int         waited;
		logic [3:0] mask;
		mask = 4'(next_rand()) | 4'b0001;
		send(make_write(REG_KEYON, 2'd0, 3'd0, {mask, 1'b0, 3'd1}), waited);
		wait_settled();
		mask = 4'(next_rand()) | 4'b1000;
		send(make_write(REG_KEYON, 2'd0, 3'd0, {mask, 1'b0, 3'd5}), waited);
		wait_settled();
		send(make_write(REG_KEYON, 2'd0, 3'd0, {4'd0, 1'b0, 3'd1}), waited);
		wait_settled();
		end_test("key-on");
	endtask

	task automatic test_backpressure();
		int waited;
		send(make_write(REG_TL, 2'(next_rand()), code_of(int'(next_rand() % 6)),
			8'(next_rand())), waited);
		send(make_write(REG_D2R, 2'(next_rand()), code_of(int'(next_rand() % 6)),
			8'(next_rand())), waited);
		if (waited < 1 || waited > `FM_SLOTS) begin
			errors++;
			$display("write behind an operator write waited %0d cycles", waited);
		end
		send(make_write(REG_FB_ALG, 2'd0, code_of(2), 8'(next_rand())), waited);
		send(make_write(REG_SSG, 2'd3, code_of(4), 8'(next_rand())), waited);
		if (waited < 1 || waited > 7) begin
			errors++;
			$display("write behind a channel write waited %0d cycles", waited);
		end
		wait_settled();
		send(make_write(REG_TL, 2'd1, 3'd3, 8'h55), waited);
		check_ready_kept();
		send(make_write(REG_FB_ALG, 2'd0, 3'd7, 8'h3f), waited);
		check_ready_kept();
		send(make_write(REG_KEYON, 2'd0, 3'd0, {4'hf, 1'b0, 3'd7}), waited);
		check_ready_kept();
		wait_settled();
		end_test("back-pressure and unused channels");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		wr_valid = 1'b0;
		wr = '0;
		rng = 32'd21;
		errors = 0;
		checks = 0;
		tests = 0;
		cycles = 0;
		quiet = 0;
		exp_idx = 0;
		init_model();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reset();
		test_op_fields();
		test_block_latch();
		test_channel_fields();
		test_keyon();
		test_backpressure();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
logic/fm_pkg.sv
logic/fm_shreg.sv
logic/fm_slot_counter.sv
logic/fm_write_port.sv
logic/fm_keyon.sv
logic/fm_reg.sv
logic/fm_reg_top.sv
sim/fm_reg_asserts.sv
sim/fm_reg_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the register file testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module fm_reg_tb \
	-Mdir obj_dir -o fm_reg_sim

./obj_dir/fm_reg_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
